//--- io_pkg.sv
// Input side definitions
package io_pkg;

	// Keys currently held on the PS/2 keyboard.
	typedef struct packed {
		logic fire;
		logic start1;
		logic start2;
		logic coin;
	} key_state_t;

	// Game control inputs, all active low.
	typedef struct packed {
		logic coin_n;
		logic start1_n;
		logic start2_n;
		logic fire_n;
		logic test_n;
	} game_ctrl_t;

	// Bit positions in the menu status word.
	localparam int STATUS_RESET      = 0;
	localparam int STATUS_SELF_TEST  = 1;
	localparam int STATUS_SCAN_LO    = 3; // Two bits wide.
	localparam int STATUS_CORE_RESET = 6;

	// Set 2 scan codes of the game keys.
	localparam logic [7:0] SC_FIRE   = 8'h29; // Space bar.
	localparam logic [7:0] SC_START1 = 8'h16;
	localparam logic [7:0] SC_START2 = 8'h1E;
	localparam logic [7:0] SC_COIN   = 8'h2E;

	localparam logic [7:0] SC_BREAK  = 8'hF0;
	localparam logic [7:0] SC_EXTEND = 8'hE0;

endpackage

//--- av_pkg.sv
// Video and audio definitions
package av_pkg;

	// Scanline dimming applied to odd lines.
	typedef enum logic [1:0] {
		SCAN_NONE = 2'd0,
		SCAN_25   = 2'd1,
		SCAN_50   = 2'd2
	} scan_mode_e;

	// Monochrome pixel as produced by the game core.
	typedef struct packed {
		logic [7:0] luma;
		logic       hsync;
		logic       vsync;
	} pixel_t;

	// VGA output with 6 bits per colour.
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_t;

	// Width of one sound channel from the core.
	localparam int AUDIO_CH_W = 7;

	// Width of the base colour value taken from the luma.
	localparam int COLOR_W = 6;

endpackage

//--- ps2_keyboard.sv
// PS/2 keyboard decoder
`timescale 1ns/1ps

module ps2_keyboard (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ps2_kbd_clk,
	input  logic               ps2_kbd_data,
	output io_pkg::key_state_t keys
);
	import io_pkg::*;

	localparam int IDLE_LIMIT = 2000;

	logic [2:0]  clk_sync; // Two synchroniser flops and the previous sample.
	logic [1:0]  data_sync;
	logic        fall;
	logic        last_bit;
	logic [3:0]  bit_cnt;
	logic [9:0]  shift;
	logic [10:0] idle_cnt;
	logic [7:0]  code;
	logic        frame_ok;
	logic        brk;
	logic        ext;

	assign fall     = clk_sync[2] & ~clk_sync[1];
	assign last_bit = (bit_cnt == 4'd10);
	assign code     = shift[8:1];

	// Start bit low, stop bit high and odd parity over data plus parity bit.
	assign frame_ok = ~shift[0] & data_sync[1] & (^shift[9:1]);

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= 3'b111;
			data_sync <= 2'b11;
		end else begin
			clk_sync  <= {clk_sync[1:0], ps2_kbd_clk};
			data_sync <= {data_sync[0], ps2_kbd_data};
		end
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			idle_cnt <= '0;
		end else if (fall) begin
			idle_cnt <= '0;
			bit_cnt  <= last_bit ? 4'd0 : bit_cnt + 4'd1;
		end else if (bit_cnt != 4'd0) begin
			// A stalled frame is abandoned so the next start bit realigns.
			if (idle_cnt == 11'(IDLE_LIMIT - 1)) begin
				bit_cnt  <= '0;
				idle_cnt <= '0;
			end else begin
				idle_cnt <= idle_cnt + 11'd1;
			end
		end
	end

	// The stop bit is checked straight from the pin and never shifted in.
	always_ff @(posedge clk_24) begin
		if (fall && !last_bit) begin
			shift <= {data_sync[1], shift[9:1]};
		end
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			keys <= '0;
			brk  <= 1'b0;
			ext  <= 1'b0;
		end else if (fall && last_bit && frame_ok) begin
			if (code == SC_BREAK) begin
				brk <= 1'b1;
			end else if (code == SC_EXTEND) begin
				ext <= 1'b1;
			end else begin
				brk <= 1'b0;
				ext <= 1'b0;
				if (!ext) begin // Extended keys share codes with game keys.
					case (code)
						SC_FIRE:   keys.fire   <= ~brk;
						SC_START1: keys.start1 <= ~brk;
						SC_START2: keys.start2 <= ~brk;
						SC_COIN:   keys.coin   <= ~brk;
						default: ;
					endcase
				end
			end
		end
	end

	a_bit_cnt_range: assert property (@(posedge clk_24) disable iff (!rst_n)
		bit_cnt <= 4'd10)
		else $error("ps2_keyboard: bit count beyond the stop bit");

endmodule

//--- control_mapper.sv
// Game control mapper
`timescale 1ns/1ps

module control_mapper (
	input  logic               clk_24,
	input  logic               rst_n,
	input  io_pkg::key_state_t keys,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [1:0]         buttons,
	input  logic [31:0]        status,
	input  logic               scandoubler_disable,
	output io_pkg::game_ctrl_t game_ctrl,
	output logic               game_reset_n,
	output av_pkg::scan_mode_e scan_mode
);
	import io_pkg::*;
	import av_pkg::*;

	localparam int JOY_FIRE = 4;

	logic       reset_req;
	game_ctrl_t ctrl_next;
	scan_mode_e scan_next;

	assign reset_req = status[STATUS_RESET] | status[STATUS_CORE_RESET] | buttons[1];

	always_comb begin
		ctrl_next.coin_n   = ~keys.coin;
		ctrl_next.start1_n = ~keys.start1;
		ctrl_next.start2_n = ~keys.start2;
		ctrl_next.fire_n   = ~(keys.fire | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE]);
		ctrl_next.test_n   = ~status[STATUS_SELF_TEST];

		// Value 1 is the HQ2x setting, which this shell does not provide.
		case (status[STATUS_SCAN_LO +: 2])
			2'd2:    scan_next = SCAN_25;
			2'd3:    scan_next = SCAN_50;
			default: scan_next = SCAN_NONE;
		endcase
		if (scandoubler_disable) begin
			scan_next = SCAN_NONE;
		end
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			game_ctrl    <= '1;
			game_reset_n <= 1'b0; // Hold the core in reset.
			scan_mode    <= SCAN_NONE;
		end else begin
			game_ctrl    <= ctrl_next;
			game_reset_n <= ~reset_req;
			scan_mode    <= scan_next;
		end
	end

	a_reset_follows: assert property (@(posedge clk_24) disable iff (!rst_n)
		reset_req |=> !game_reset_n)
		else $error("control_mapper: game reset not asserted after a reset source");

endmodule

//--- audio_dac.sv
// Delta-sigma audio DAC
`timescale 1ns/1ps

module audio_dac #(
	parameter int SAMPLE_W = 8
) (
	input  logic       clk_24,
	input  logic       rst_n,
	input  logic [6:0] audio1,
	input  logic [6:0] audio2,
	output logic       audio_out
);

	logic [SAMPLE_W-1:0] sample;
	logic [SAMPLE_W-1:0] acc;
	logic [SAMPLE_W:0]   acc_sum;

	// The sample is wide enough that the two channels never overflow.
	assign sample  = SAMPLE_W'(audio1) + SAMPLE_W'(audio2);
	assign acc_sum = {1'b0, acc} + {1'b0, sample};

	// The carry out of the accumulator is the pulse density output.
	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			acc       <= '0;
			audio_out <= 1'b0;
		end else begin
			acc       <= acc_sum[SAMPLE_W-1:0];
			audio_out <= acc_sum[SAMPLE_W];
		end
	end

	a_out_known: assert property (@(posedge clk_24) disable iff (!rst_n)
		!$isunknown(audio_out))
		else $error("audio_dac: output is unknown");

endmodule

//--- scanline_video.sv
// Scanline video output
`timescale 1ns/1ps

module scanline_video (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ce_pix,
	input  av_pkg::pixel_t     game_pixel,
	input  av_pkg::scan_mode_e scan_mode,
	output av_pkg::vga_t       vga
);
	import av_pkg::*;

	logic               hs_prev;
	logic               vs_prev;
	logic               line_odd;
	logic [COLOR_W-1:0] base;
	logic [COLOR_W-1:0] level;

	assign base = game_pixel.luma[7:2];

	always_comb begin
		level = base;
		if (line_odd) begin
			case (scan_mode)
				SCAN_25: level = base - (base >> 2);
				SCAN_50: level = base >> 1;
				default: level = base;
			endcase
		end
	end

	always_ff @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			hs_prev  <= 1'b0;
			vs_prev  <= 1'b0;
			line_odd <= 1'b0;
			vga      <= '0;
		end else if (ce_pix) begin
			hs_prev <= game_pixel.hsync;
			vs_prev <= game_pixel.vsync;
			// A new frame always starts on an even line.
			if (game_pixel.vsync && !vs_prev) begin
				line_odd <= 1'b0;
			end else if (game_pixel.hsync && !hs_prev) begin
				line_odd <= ~line_odd;
			end
			vga.r  <= level;
			vga.g  <= level;
			vga.b  <= level;
			vga.hs <= game_pixel.hsync;
			vga.vs <= game_pixel.vsync;
		end
	end

	a_vga_hold: assert property (@(posedge clk_24) disable iff (!rst_n)
		!ce_pix |=> $stable(vga))
		else $error("scanline_video: vga changed without ce_pix");

endmodule

//--- arcade_shell.sv
// Arcade host shell top level
`timescale 1ns/1ps

module arcade_shell (
	input  logic               clk_24,
	input  logic               rst_n,
	input  logic               ps2_kbd_clk,
	input  logic               ps2_kbd_data,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic [1:0]         buttons,
	input  logic [31:0]        status,
	input  logic               scandoubler_disable,
	input  logic               ce_pix,
	input  av_pkg::pixel_t     game_pixel,
	input  logic [6:0]         audio1,
	input  logic [6:0]         audio2,
	output io_pkg::game_ctrl_t game_ctrl,
	output logic               game_reset_n,
	output av_pkg::vga_t       vga,
	output logic               audio_out
);
	import io_pkg::*;
	import av_pkg::*;

	// One bit of headroom holds the sum of both channels.
	localparam int DAC_SAMPLE_W = AUDIO_CH_W + 1;

	key_state_t keys;
	scan_mode_e scan_mode;

	ps2_keyboard ps2_keyboard_inst (
		.clk_24       (clk_24),
		.rst_n        (rst_n),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.keys         (keys)
	);

	control_mapper control_mapper_inst (
		.clk_24              (clk_24),
		.rst_n               (rst_n),
		.keys                (keys),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.buttons             (buttons),
		.status              (status),
		.scandoubler_disable (scandoubler_disable),
		.game_ctrl           (game_ctrl),
		.game_reset_n        (game_reset_n),
		.scan_mode           (scan_mode)
	);

	audio_dac #(
		.SAMPLE_W (DAC_SAMPLE_W)
	) audio_dac_inst (
		.clk_24    (clk_24),
		.rst_n     (rst_n),
		.audio1    (audio1),
		.audio2    (audio2),
		.audio_out (audio_out)
	);

	scanline_video scanline_video_inst (
		.clk_24     (clk_24),
		.rst_n      (rst_n),
		.ce_pix     (ce_pix),
		.game_pixel (game_pixel),
		.scan_mode  (scan_mode),
		.vga        (vga)
	);

endmodule

//--- tb_arcade_shell.sv
// Arcade shell testbench
`timescale 1ns/1ps

module tb_arcade_shell;
	import io_pkg::*;
	import av_pkg::*;

	localparam int TIMEOUT_CYCLES = 40000; // About 24 PS/2 frames, four DAC windows and video.
	localparam int PS2_HALF       = 20;
	localparam int VIDEO_CYCLES   = 400;

	logic        clk_24;
	logic        rst_n;
	logic        ps2_kbd_clk;
	logic        ps2_kbd_data;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [1:0]  buttons;
	logic [31:0] status;
	logic        scandoubler_disable;
	logic        ce_pix;
	pixel_t      game_pixel;
	logic [6:0]  audio1;
	logic [6:0]  audio2;
	game_ctrl_t  game_ctrl;
	logic        game_reset_n;
	vga_t        vga;
	logic        audio_out;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          cycles;
	key_state_t  held; // Keys the model believes are held down.
	scan_mode_e  model_mode;
	logic        model_odd;
	logic        model_hs;
	logic        model_vs;
	logic [5:0]  model_level;
	vga_t        exp_vga;
	logic        video_on;
	logic [7:0]  model_acc;
	logic        model_bit;

	arcade_shell arcade_shell_inst (
		.clk_24              (clk_24),
		.rst_n               (rst_n),
		.ps2_kbd_clk         (ps2_kbd_clk),
		.ps2_kbd_data        (ps2_kbd_data),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.buttons             (buttons),
		.status              (status),
		.scandoubler_disable (scandoubler_disable),
		.ce_pix              (ce_pix),
		.game_pixel          (game_pixel),
		.audio1              (audio1),
		.audio2              (audio2),
		.game_ctrl           (game_ctrl),
		.game_reset_n        (game_reset_n),
		.vga                 (vga),
		.audio_out           (audio_out)
	);

	initial clk_24 = 1'b0;
	always #2 clk_24 = ~clk_24;

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_24);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0]; // Taps 32, 22, 2 and 1.
		return {s[30:0], fb};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic logic [7:0] key_code(input logic [1:0] k);
		case (k)
			2'd0:    return SC_FIRE;
			2'd1:    return SC_START1;
			2'd2:    return SC_START2;
			default: return SC_COIN;
		endcase
	endfunction

	function automatic game_ctrl_t expect_ctrl(input key_state_t k, input logic [7:0] j0,
			input logic [7:0] j1, input logic [31:0] st);
		game_ctrl_t c;
		c.coin_n   = !k.coin;
		c.start1_n = !k.start1;
		c.start2_n = !k.start2;
		c.fire_n   = !(k.fire || j0[4] || j1[4]);
		c.test_n   = !st[STATUS_SELF_TEST];
		return c;
	endfunction

	function automatic logic [5:0] dim_level(input logic [7:0] luma, input scan_mode_e mode,
			input logic odd);
		logic [5:0] v;
		v = luma[7:2];
		if (odd && mode == SCAN_25) begin
			return v - (v >> 2);
		end else if (odd && mode == SCAN_50) begin
			return v >> 1;
		end
		return v;
	endfunction

	function automatic scan_mode_e mode_of(input logic [1:0] sel, input logic sd);
		if (sd || sel < 2'd2) begin
			return SCAN_NONE;
		end
		return (sel == 2'd2) ? SCAN_25 : SCAN_50;
	endfunction

	// A pixel is dimmed with the line parity in effect before it.
	always @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			model_odd <= 1'b0;
			model_hs  <= 1'b0;
			model_vs  <= 1'b0;
			exp_vga   <= '0;
		end else if (ce_pix) begin
			model_level = dim_level(game_pixel.luma, model_mode, model_odd);
			exp_vga  <= {model_level, model_level, model_level, game_pixel.hsync, game_pixel.vsync};
			model_hs <= game_pixel.hsync;
			model_vs <= game_pixel.vsync;
			if (game_pixel.vsync && !model_vs) begin
				model_odd <= 1'b0;
			end else if (game_pixel.hsync && !model_hs) begin
				model_odd <= ~model_odd;
			end
		end
	end

	always @(posedge clk_24 or negedge rst_n) begin
		if (!rst_n) begin
			model_acc <= '0;
			model_bit <= 1'b0;
		end else begin
			{model_bit, model_acc} <= 9'(model_acc) + 9'(audio1) + 9'(audio2); // Carry is the output.
		end
	end

	always @(negedge clk_24) begin
		if (video_on) begin
			check_value("vga", 32'(vga), 32'(exp_vga));
		end
	end

	// Start bit, eight data bits LSB first, odd parity, stop bit.
	task automatic send_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		int          i;
		frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			@(posedge clk_24);
			ps2_kbd_data <= frame[i];
			repeat (PS2_HALF - 1) @(posedge clk_24);
			ps2_kbd_clk <= 1'b0;
			repeat (PS2_HALF) @(posedge clk_24);
			ps2_kbd_clk <= 1'b1;
		end
	endtask

	task automatic key_event(input logic [1:0] k, input logic rel);
		if (rel) begin
			send_frame(SC_BREAK, 1'b0);
		end
		send_frame(key_code(k), 1'b0);
		held[3 - int'(k)] = !rel;
	endtask

	task automatic check_ctrl();
		repeat (8) @(posedge clk_24);
		@(negedge clk_24);
		check_value("game_ctrl", 32'(game_ctrl),
			32'(expect_ctrl(held, joystick_0, joystick_1, status)));
	endtask

	task automatic key_tests();
		logic [31:0] r;
		logic [7:0]  j0;
		logic [7:0]  j1;
		int          n;
		for (n = 0; n < 8; n++) begin
			take_bits(19, r);
			j0 = r[10:3];
			j1 = r[18:11];
			if (n < 5) begin // Keys alone first, then with the joysticks.
				j0[4] = 1'b0;
				j1[4] = 1'b0;
			end
			@(posedge clk_24);
			joystick_0 <= j0;
			joystick_1 <= j1;
			key_event(r[2:1], r[0]);
			check_ctrl();
		end
	endtask

	task automatic bad_frame_tests();
		logic [31:0] r;
		logic [7:0]  code;
		take_bits(2, r);
		code = key_code(r[1:0]);
		@(posedge clk_24);
		joystick_0 <= '0; // A joystick fire would hide the fire key.
		joystick_1 <= '0;
		key_event(r[1:0], 1'b1); // Released, so a stray make would show.
		check_ctrl();
		send_frame(code, 1'b1);
		check_ctrl();
		send_frame(SC_EXTEND, 1'b0);
		send_frame(code, 1'b0);
		check_ctrl();
		send_frame(8'h1C, 1'b0);
		check_ctrl();
		key_event(r[1:0], 1'b0);
		check_ctrl();
	endtask

	task automatic reset_tests();
		logic [31:0] r;
		logic [31:0] st;
		logic [1:0]  btn;
		int          n;
		for (n = 0; n < 9; n++) begin
			take_bits(3, r);
			st  = '0;
			btn = '0;
			case (r[1:0])
				2'd0:    st[STATUS_RESET] = 1'b1;
				2'd1:    st[STATUS_CORE_RESET] = 1'b1;
				2'd2:    btn[1] = 1'b1;
				default: btn[0] = 1'b1; // Not a reset source.
			endcase
			st[STATUS_SELF_TEST] = r[2];
			if (n == 8) begin
				st  = '0;
				btn = '0;
			end
			@(posedge clk_24);
			status  <= st;
			buttons <= btn;
			@(posedge clk_24);
			@(negedge clk_24);
			check_value("game_reset_n", 32'(game_reset_n),
				32'(!(st[STATUS_RESET] || st[STATUS_CORE_RESET] || btn[1])));
			check_value("game_ctrl.test_n", 32'(game_ctrl.test_n), 32'(!st[STATUS_SELF_TEST]));
		end
	endtask

	task automatic audio_tests();
		logic [31:0] r;
		int          w;
		int          i;
		int          ones;
		for (w = 0; w < 4; w++) begin
			take_bits(14, r);
			@(posedge clk_24);
			audio1 <= r[6:0];
			audio2 <= r[13:7];
			@(posedge clk_24);
			ones = 0;
			for (i = 0; i < 256; i++) begin
				@(negedge clk_24);
				ones += int'(audio_out);
				check_value("audio_out", 32'(audio_out), 32'(model_bit));
				@(posedge clk_24);
			end
			check_value("audio_out ones per window", 32'(ones), 32'(r[6:0]) + 32'(r[13:7]));
		end
	endtask

	task automatic video_tests();
		logic [31:0] r;
		logic [1:0]  sel;
		pixel_t      p;
		int          m;
		int          c;
		int          px;
		int          ln;
		px = 0;
		ln = 0;
		video_on <= 1'b1;
		for (m = 0; m < 4; m++) begin
			sel = (m == 0) ? 2'd2 : ((m == 2) ? 2'd0 : 2'd3);
			@(posedge clk_24);
			ce_pix              <= 1'b0;
			status              <= {27'd0, sel, 3'd0};
			scandoubler_disable <= (m == 3);
			model_mode          <= mode_of(sel, m == 3);
			repeat (2) @(posedge clk_24); // The scan mode is registered once more.
			for (c = 0; c < VIDEO_CYCLES; c++) begin
				take_bits(9, r);
				p.luma  = r[7:0];
				p.hsync = (px >= 12);
				p.vsync = (ln == 0);
				ce_pix     <= r[8];
				game_pixel <= p;
				px = (px + 1) % 16;
				if (px == 0) begin
					ln = (ln + 1) % 5;
				end
				@(posedge clk_24);
			end
		end
		ce_pix <= 1'b0;
		repeat (2) @(posedge clk_24);
		video_on <= 1'b0;
	endtask

	initial begin
		rst_n               <= 1'b0;
		ps2_kbd_clk         <= 1'b1;
		ps2_kbd_data        <= 1'b1;
		joystick_0          <= '0;
		joystick_1          <= '0;
		buttons             <= '0;
		status              <= '0;
		scandoubler_disable <= 1'b0;
		ce_pix              <= 1'b0;
		game_pixel          <= '0;
		audio1              <= '0;
		audio2              <= '0;
		model_mode          <= SCAN_NONE;
		video_on            <= 1'b0;
		lfsr   = 32'h06577bd7;
		errors = 0;
		checks = 0;
		held   = '0;
		repeat (15) @(posedge clk_24);
		@(negedge clk_24);
		check_value("game_reset_n", 32'(game_reset_n), 32'd0);
		check_value("game_ctrl", 32'(game_ctrl), 32'h1F);
		check_value("vga", 32'(vga), 32'd0);
		check_value("audio_out", 32'(audio_out), 32'd0);
		@(posedge clk_24);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk_24);
		key_tests();
		bad_frame_tests();
		reset_tests();
		audio_tests();
		video_tests();
		repeat (4) @(posedge clk_24);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- arcade_shell.f
io_pkg.sv
av_pkg.sv
ps2_keyboard.sv
control_mapper.sv
audio_dac.sv
scanline_video.sv
arcade_shell.sv
tb_arcade_shell.sv

//--- run_sim.sh
#!/bin/sh
# Compile the arcade shell testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arcade_shell \
	-f arcade_shell.f \
	-o sim_arcade_shell

./obj_dir/sim_arcade_shell > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "No result line found in sim.log"
	exit 1
fi
exit 0
